// File: rtl/trace_pkg.sv
/*
  Shared definitions for the instruction tracer:
  widths, RV32I major opcodes and the nop encoding,
  instruction class enum, instruction word union,
  trace record and the EX / WB observation structs,
  rd write-back capture helper
*/

package trace_pkg;

  parameter int xlen_w     = 32;
  parameter int reg_addr_w = 5;
  parameter int cycle_w    = 32;

  // base RV32I major opcodes
  parameter logic [6:0] opc_lui      = 7'b0110111;
  parameter logic [6:0] opc_auipc    = 7'b0010111;
  parameter logic [6:0] opc_jal      = 7'b1101111;
  parameter logic [6:0] opc_jalr     = 7'b1100111;
  parameter logic [6:0] opc_branch   = 7'b1100011;
  parameter logic [6:0] opc_load     = 7'b0000011;
  parameter logic [6:0] opc_store    = 7'b0100011;
  parameter logic [6:0] opc_op_imm   = 7'b0010011;
  parameter logic [6:0] opc_op       = 7'b0110011;
  parameter logic [6:0] opc_misc_mem = 7'b0001111;
  parameter logic [6:0] opc_system   = 7'b1110011;

  // addi x0, x0, 0
  parameter logic [xlen_w-1:0] nop_word = 32'h0000_0013;

  typedef enum logic [3:0] {
    cls_nop, cls_lui, cls_auipc, cls_jal, cls_jalr, cls_branch, cls_op_imm,
    cls_op, cls_load, cls_store, cls_fence, cls_csr, cls_system, cls_invalid
  } instr_class_e;

  typedef struct packed {
    logic [6:0]            funct7;
    logic [reg_addr_w-1:0] rs2;
    logic [reg_addr_w-1:0] rs1;
    logic [2:0]            funct3;
    logic [reg_addr_w-1:0] rd;
    logic [6:0]            opcode;
  } r_view_t;

  typedef struct packed {
    logic [11:0]           imm12;
    logic [reg_addr_w-1:0] rs1;
    logic [2:0]            funct3;
    logic [reg_addr_w-1:0] rd;
    logic [6:0]            opcode;
  } i_view_t;

  // same 32 bits, register form or immediate form
  typedef union packed {
    r_view_t r;
    i_view_t i;
  } instr_word_u;

  typedef struct packed {
    logic [cycle_w-1:0]    cycle;
    logic [xlen_w-1:0]     pc;
    logic [xlen_w-1:0]     instr;
    instr_class_e          iclass;
    logic [reg_addr_w-1:0] rd;
    logic                  rd_valid;
    logic [xlen_w-1:0]     rd_value;
    logic [xlen_w-1:0]     rs1_value;
    logic [xlen_w-1:0]     rs2_value;
    logic                  mem_valid;
    logic                  mem_we;
    logic [xlen_w-1:0]     mem_addr;
    logic [xlen_w-1:0]     mem_wdata;
  } trace_rec_t;

  typedef struct packed {
    logic                  ex_valid;
    logic                  reg_we;
    logic [reg_addr_w-1:0] reg_addr;
    logic [xlen_w-1:0]     reg_wdata;
    logic                  data_req;
    logic                  data_gnt;
    logic                  data_we;
    logic [xlen_w-1:0]     data_addr;
    logic [xlen_w-1:0]     data_wdata;
    logic                  wb_bypass;
  } ex_obs_t;

  typedef struct packed {
    logic                  wb_valid;
    logic                  reg_we;
    logic [reg_addr_w-1:0] reg_addr;
    logic [xlen_w-1:0]     reg_wdata;
  } wb_obs_t;

  // later writes to the traced rd overwrite earlier ones
  function automatic trace_rec_t capture_rd(input trace_rec_t            rec,
                                            input logic                  we,
                                            input logic [reg_addr_w-1:0] addr,
                                            input logic [xlen_w-1:0]     wdata);
    trace_rec_t upd;
    upd = rec;
    if (we && rec.rd_valid && (addr == rec.rd)) begin
      upd.rd_value = wdata;
    end
    return upd;
  endfunction

endpackage

// File: rtl/instr_classifier.sv
/*
  Combinational RV32I decoder for the tracer.
  Maps an instruction word to its class and flags
  whether the class writes a non-zero rd.
*/

`timescale 1ns/1ps

module instr_classifier (
  input  trace_pkg::instr_word_u  instr,
  output trace_pkg::instr_class_e iclass,
  output logic                    writes_rd
);

  import trace_pkg::*;

  always_comb begin
    iclass = cls_invalid;
    if (instr == nop_word) begin
      iclass = cls_nop;
    end else begin
      case (instr.r.opcode)
        opc_lui:      iclass = cls_lui;
        opc_auipc:    iclass = cls_auipc;
        opc_jal:      iclass = cls_jal;
        opc_jalr:     iclass = cls_jalr;
        opc_branch:   iclass = cls_branch;
        opc_op_imm:   iclass = cls_op_imm;
        opc_misc_mem: iclass = cls_fence;
        opc_op: begin
          // base ALU ops only, everything else is an extension
          if ((instr.r.funct7 == 7'h00) || (instr.r.funct7 == 7'h20)) begin
            iclass = cls_op;
          end
        end
        opc_load: begin
          // lb lh lw lbu lhu
          case (instr.i.funct3)
            3'b000, 3'b001, 3'b010, 3'b100, 3'b101: iclass = cls_load;
            default:                                iclass = cls_invalid;
          endcase
        end
        opc_store: begin
          // sb sh sw
          case (instr.i.funct3)
            3'b000, 3'b001, 3'b010: iclass = cls_store;
            default:                iclass = cls_invalid;
          endcase
        end
        opc_system: begin
          if (instr.i.funct3 == 3'b000) begin
            // ecall / ebreak, other privileged encodings are not traced as valid
            if ((instr.i.imm12 == 12'd0) || (instr.i.imm12 == 12'd1)) begin
              iclass = cls_system;
            end
          end else if (instr.i.funct3 != 3'b100) begin
            iclass = cls_csr;
          end
        end
        default: iclass = cls_invalid;
      endcase
    end
  end

  // classes with a destination register
  always_comb begin
    case (iclass)
      cls_lui, cls_auipc, cls_jal, cls_jalr,
      cls_op_imm, cls_op, cls_load, cls_csr:
        writes_rd = (instr.r.rd != '0);
      default:
        writes_rd = 1'b0;
    endcase
  end

endmodule

// File: rtl/trace_issue.sv
/*
  Decode-stage side of the tracer:
  cycle counter, sticky fetch_enable latch and
  creation of a fresh trace record per accepted instruction
*/

`timescale 1ns/1ps

module trace_issue (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          fetch_enable,
  input  logic [trace_pkg::xlen_w-1:0]  pc,
  input  logic [trace_pkg::xlen_w-1:0]  instr,
  input  logic                          id_valid,
  input  logic                          is_decoding,
  input  logic                          pipe_flush,
  input  logic [trace_pkg::xlen_w-1:0]  rs1_value,
  input  logic [trace_pkg::xlen_w-1:0]  rs2_value,
  output logic                          issue_valid,
  output trace_pkg::trace_rec_t         issue_rec
);

  import trace_pkg::*;

  logic [cycle_w-1:0] cycle_cnt;
  logic               started;
  instr_word_u        instr_w;
  instr_class_e       iclass;
  logic               writes_rd;

  assign instr_w = instr;

  instr_classifier u_classifier (
    .instr     (instr_w),
    .iclass    (iclass),
    .writes_rd (writes_rd)
  );

  // counter reads 0 on the first edge out of reset
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cycle_cnt <= '0;
      started   <= 1'b0;
    end else begin
      cycle_cnt <= cycle_cnt + cycle_w'(1);
      if (fetch_enable) begin
        started <= 1'b1;
      end
    end
  end

  // the edge that first sees fetch_enable already counts as started
  assign issue_valid = (started || fetch_enable) &&
                       ((id_valid && is_decoding) || pipe_flush);

  always_comb begin
    issue_rec           = '0;
    issue_rec.cycle     = cycle_cnt;
    issue_rec.pc        = pc;
    issue_rec.instr     = instr;
    issue_rec.iclass    = iclass;
    issue_rec.rd        = instr_w.r.rd;
    issue_rec.rd_valid  = writes_rd;
    issue_rec.rs1_value = rs1_value;
    issue_rec.rs2_value = rs2_value;
  end

endmodule

// File: rtl/ex_tracker.sv
/*
  Shadow EX slot of the tracer.
  Holds one record, captures rd write-back and the first
  granted data access, retires to WB or straight out on bypass
*/

`timescale 1ns/1ps

module ex_tracker (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  issue_valid,
  input  trace_pkg::trace_rec_t issue_rec,
  input  trace_pkg::ex_obs_t    ex_obs,
  output logic                  to_wb_valid,
  output trace_pkg::trace_rec_t to_wb_rec,
  output logic                  bypass_valid,
  output trace_pkg::trace_rec_t bypass_rec
);

  import trace_pkg::*;

  logic       occupied;
  trace_rec_t rec;
  trace_rec_t rec_upd;
  logic       retire;

  // record as it looks after this edge's observation
  always_comb begin
    rec_upd = capture_rd(rec, ex_obs.reg_we, ex_obs.reg_addr, ex_obs.reg_wdata);
    // only the first granted access is kept
    if (ex_obs.data_req && ex_obs.data_gnt && !rec.mem_valid) begin
      rec_upd.mem_valid = 1'b1;
      rec_upd.mem_we    = ex_obs.data_we;
      rec_upd.mem_addr  = ex_obs.data_addr;
      rec_upd.mem_wdata = ex_obs.data_we ? ex_obs.data_wdata : '0;
    end
  end

  assign retire = occupied && (ex_obs.ex_valid || ex_obs.wb_bypass);

  // ex branches skip the WB stage
  assign to_wb_valid  = retire && !ex_obs.wb_bypass;
  assign bypass_valid = retire && ex_obs.wb_bypass;
  assign to_wb_rec    = rec_upd;
  assign bypass_rec   = rec_upd;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      occupied <= 1'b0;
    end else if (issue_valid) begin
      occupied <= 1'b1;
    end else if (retire) begin
      occupied <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (issue_valid) begin
      rec <= issue_rec;
    end else if (occupied) begin
      rec <= rec_upd;
    end
  end

endmodule

// File: rtl/wb_tracker.sv
/*
  Shadow WB slot of the tracer.
  Captures the late rd write-back and retires on wb_valid.
*/

`timescale 1ns/1ps

module wb_tracker (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  to_wb_valid,
  input  trace_pkg::trace_rec_t to_wb_rec,
  input  trace_pkg::wb_obs_t    wb_obs,
  output logic                  done_valid,
  output trace_pkg::trace_rec_t done_rec
);

  import trace_pkg::*;

  logic       occupied;
  trace_rec_t rec;

  assign done_rec   = capture_rd(rec, wb_obs.reg_we, wb_obs.reg_addr, wb_obs.reg_wdata);
  assign done_valid = occupied && wb_obs.wb_valid;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      occupied <= 1'b0;
    end else if (to_wb_valid) begin
      occupied <= 1'b1;
    end else if (done_valid) begin
      occupied <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (to_wb_valid) begin
      rec <= to_wb_rec;
    end else if (occupied) begin
      rec <= done_rec;
    end
  end

endmodule

// File: rtl/trace_emitter.sv
/*
  Output side of the tracer:
  circular record FIFO with two push ports (a before b),
  saturating drop counter and four-phase req/ack port
*/

`timescale 1ns/1ps

module trace_emitter #(
  parameter int fifo_depth = 4
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  push_a_valid,
  input  trace_pkg::trace_rec_t push_a_rec,
  input  logic                  push_b_valid,
  input  trace_pkg::trace_rec_t push_b_rec,
  input  logic                  trace_ack,
  output trace_pkg::trace_rec_t trace_rec,
  output logic                  trace_req,
  output logic [15:0]           dropped_count
);

  import trace_pkg::*;

  localparam int ptr_w = $clog2(fifo_depth);

  trace_rec_t       mem [fifo_depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [ptr_w-1:0] b_ptr;
  logic [ptr_w:0]   count;
  logic [ptr_w:0]   space;
  logic             accept_a;
  logic             accept_b;
  logic [1:0]       n_push;
  logic [1:0]       n_drop;
  logic             pop;
  logic [16:0]      drop_sum;

  ////////////////////////////////////////////////////////////////////////////
  // push side
  ////////////////////////////////////////////////////////////////////////////

  // a slot freed by this edge's pop is not reused until the next edge
  assign space    = (ptr_w+1)'(fifo_depth) - count;
  assign accept_a = push_a_valid && (space != '0);
  assign accept_b = push_b_valid && (space > (ptr_w+1)'(accept_a));
  assign b_ptr    = wr_ptr + ptr_w'(accept_a);
  assign n_push   = {1'b0, accept_a} + {1'b0, accept_b};
  assign n_drop   = {1'b0, push_a_valid && !accept_a} + {1'b0, push_b_valid && !accept_b};
  assign drop_sum = {1'b0, dropped_count} + 17'(n_drop);

  always_ff @(posedge clk) begin
    if (accept_a) begin
      mem[wr_ptr] <= push_a_rec;
    end
    if (accept_b) begin
      mem[b_ptr] <= push_b_rec;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // four-phase output
  ////////////////////////////////////////////////////////////////////////////

  // head stays put while req is high
  assign trace_rec = mem[rd_ptr];
  assign pop       = trace_req && trace_ack;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      count         <= '0;
      trace_req     <= 1'b0;
      dropped_count <= '0;
    end else begin
      wr_ptr <= wr_ptr + ptr_w'(n_push);
      rd_ptr <= rd_ptr + ptr_w'(pop);
      count  <= count + (ptr_w+1)'(n_push) - (ptr_w+1)'(pop);
      // rising needs ack low, so a new phase waits for the old ack to drop
      if (!trace_req && !trace_ack && (count != '0)) begin
        trace_req <= 1'b1;
      end else if (pop) begin
        trace_req <= 1'b0;
      end
      if (drop_sum[16]) begin
        dropped_count <= 16'hffff;
      end else begin
        dropped_count <= drop_sum[15:0];
      end
    end
  end

endmodule

// File: rtl/riscv_trace_top.sv
/*
  Top level of the instruction tracer.
  Chains issue, shadow EX, shadow WB and the emitter
  and sets the output FIFO depth.
*/

`timescale 1ns/1ps

module riscv_trace_top #(
  parameter int fifo_depth = 4
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          fetch_enable,
  input  logic [trace_pkg::xlen_w-1:0]  pc,
  input  logic [trace_pkg::xlen_w-1:0]  instr,
  input  logic                          id_valid,
  input  logic                          is_decoding,
  input  logic                          pipe_flush,
  input  logic [trace_pkg::xlen_w-1:0]  rs1_value,
  input  logic [trace_pkg::xlen_w-1:0]  rs2_value,
  input  trace_pkg::ex_obs_t            ex_obs,
  input  trace_pkg::wb_obs_t            wb_obs,
  output trace_pkg::trace_rec_t         trace_rec,
  output logic                          trace_req,
  input  logic                          trace_ack,
  output logic [15:0]                   dropped_count
);

  import trace_pkg::*;

  logic       issue_valid;
  trace_rec_t issue_rec;
  logic       to_wb_valid;
  trace_rec_t to_wb_rec;
  logic       bypass_valid;
  trace_rec_t bypass_rec;
  logic       done_valid;
  trace_rec_t done_rec;

  trace_issue u_issue (
    .clk          (clk),
    .rst_n        (rst_n),
    .fetch_enable (fetch_enable),
    .pc           (pc),
    .instr        (instr),
    .id_valid     (id_valid),
    .is_decoding  (is_decoding),
    .pipe_flush   (pipe_flush),
    .rs1_value    (rs1_value),
    .rs2_value    (rs2_value),
    .issue_valid  (issue_valid),
    .issue_rec    (issue_rec)
  );

  ex_tracker u_ex (
    .clk          (clk),
    .rst_n        (rst_n),
    .issue_valid  (issue_valid),
    .issue_rec    (issue_rec),
    .ex_obs       (ex_obs),
    .to_wb_valid  (to_wb_valid),
    .to_wb_rec    (to_wb_rec),
    .bypass_valid (bypass_valid),
    .bypass_rec   (bypass_rec)
  );

  wb_tracker u_wb (
    .clk         (clk),
    .rst_n       (rst_n),
    .to_wb_valid (to_wb_valid),
    .to_wb_rec   (to_wb_rec),
    .wb_obs      (wb_obs),
    .done_valid  (done_valid),
    .done_rec    (done_rec)
  );

  // WB retire is the older instruction, so it takes port a
  trace_emitter #(
    .fifo_depth (fifo_depth)
  ) u_emitter (
    .clk           (clk),
    .rst_n         (rst_n),
    .push_a_valid  (done_valid),
    .push_a_rec    (done_rec),
    .push_b_valid  (bypass_valid),
    .push_b_rec    (bypass_rec),
    .trace_ack     (trace_ack),
    .trace_rec     (trace_rec),
    .trace_req     (trace_req),
    .dropped_count (dropped_count)
  );

endmodule

// File: sim/tracer_properties.sv
/*
  Concurrent checks for the tracer, bound into
  trace_emitter (req/ack handshake, FIFO overflow)
  and ex_tracker (issue into a busy EX slot)
*/

`timescale 1ns/1ps

module tracer_properties (
  input logic                  clk,
  input logic                  rst_n,
  input logic                  req,
  input logic                  ack,
  input trace_pkg::trace_rec_t rec,
  input logic                  full,
  input logic                  push_any,
  input logic [15:0]           drops,
  input logic                  issue_valid,
  input logic                  occupied,
  input logic                  retire
);

  // record and req hold until ack is seen
  req_hold: assert property (@(posedge clk) disable iff (!rst_n)
    req && !ack |=> req && $stable(rec)) else $error("req dropped or record changed before ack");

  // no pop without ack
  req_fall: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(req) |-> $past(ack)) else $error("req fell without ack");

  req_rise: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(req) |-> !$past(ack)) else $error("req rose while ack high");

  issue_free: assert property (@(posedge clk) disable iff (!rst_n)
    issue_valid && occupied |-> retire) else $error("issue into busy EX slot");

  full_drop: assert property (@(posedge clk) disable iff (!rst_n)
    full && push_any && (drops != 16'hffff) |=> drops != $past(drops))
    else $error("push into full FIFO not counted");

endmodule

// File: sim/tb_tracer.sv
/*
  Testbench for riscv_trace_top:
  clock and reset, LFSR driven core stimulus,
  reference model of the EX / WB slots and output FIFO,
  record checks, drop count check and timeout
*/

`timescale 1ns/1ps

module tb_tracer;

  import trace_pkg::*;

  localparam int depth     = 4;
  localparam int n_instr   = 2000;
  localparam int max_cycle = n_instr * 40 + 200;

  logic               clk;
  logic               rst_n;
  logic               fetch_enable;
  logic [xlen_w-1:0]  pc;
  logic [xlen_w-1:0]  instr;
  logic               id_valid;
  logic               is_decoding;
  logic               pipe_flush;
  logic [xlen_w-1:0]  rs1_value;
  logic [xlen_w-1:0]  rs2_value;
  ex_obs_t            ex_obs;
  wb_obs_t            wb_obs;
  trace_rec_t         trace_rec;
  logic               trace_req;
  logic               trace_ack;
  logic [15:0]        dropped_count;

  // reference model state
  trace_rec_t m_ex;
  trace_rec_t m_wb;
  trace_rec_t mq[$];
  logic       m_ex_occ;
  logic       m_wb_occ;
  logic       m_started;
  logic       m_req;
  logic [15:0] m_drops;
  logic [31:0] m_cycle;

  logic [31:0] lfsr_state;
  int          n_issued;
  int          n_checked;
  int          n_errors;
  int          cyc;
  int          ack_delay;
  logic        phase_checked;
  logic        finished;
  logic        timed_out;

  riscv_trace_top #(.fifo_depth(depth)) dut0 (.*);

  bind trace_emitter tracer_properties emit_props (
    .clk(clk), .rst_n(rst_n), .req(trace_req), .ack(trace_ack), .rec(trace_rec),
    .full(count == (ptr_w+1)'(fifo_depth)), .push_any(push_a_valid || push_b_valid),
    .drops(dropped_count), .issue_valid(1'b0), .occupied(1'b0), .retire(1'b0)
  );

  bind ex_tracker tracer_properties ex_props (
    .clk(clk), .rst_n(rst_n), .req(1'b0), .ack(1'b0), .rec('0),
    .full(1'b0), .push_any(1'b0), .drops(16'h0000),
    .issue_valid(issue_valid), .occupied(occupied), .retire(retire)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // random numbers and expected decode
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic next_bit();
    logic b;
    b = lfsr_state[0];
    lfsr_state = b ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
    return b;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r[i] = next_bit();
    end
    return r;
  endfunction

  function automatic instr_class_e expected_class(input logic [31:0] w);
    logic [2:0] f3;
    f3 = w[14:12];
    if (w == nop_word) return cls_nop;
    case (w[6:0])
      opc_lui:      return cls_lui;
      opc_auipc:    return cls_auipc;
      opc_jal:      return cls_jal;
      opc_jalr:     return cls_jalr;
      opc_branch:   return cls_branch;
      opc_op_imm:   return cls_op_imm;
      opc_misc_mem: return cls_fence;
      opc_op:       return (w[31:25] == 7'h00 || w[31:25] == 7'h20) ? cls_op : cls_invalid;
      opc_load:     return (f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5}) ? cls_load : cls_invalid;
      opc_store:    return (f3 inside {3'd0, 3'd1, 3'd2}) ? cls_store : cls_invalid;
      opc_system: begin
        if (f3 == 3'd0) return (w[31:20] <= 12'd1) ? cls_system : cls_invalid;
        return (f3 == 3'd4) ? cls_invalid : cls_csr;
      end
      default:      return cls_invalid;
    endcase
  endfunction

  // mostly valid opcodes, some raw words and nops
  function automatic logic [31:0] make_instr();
    logic [6:0]  opc_tab [11];
    logic [31:0] w;
    logic [3:0]  sel;
    opc_tab = '{opc_lui, opc_auipc, opc_jal, opc_jalr, opc_branch, opc_load,
                opc_store, opc_op_imm, opc_op, opc_misc_mem, opc_system};
    sel = 4'(rand_bits(4));
    w   = rand_bits(32);
    if (sel == 4'd0) return nop_word;
    if (sel == 4'd1) return w;
    w[6:0] = opc_tab[4'(rand_bits(4) % 11)];
    if (w[6:0] == opc_op && next_bit()) w[31:25] = {1'b0, next_bit(), 5'b0};
    if (w[6:0] == opc_system && next_bit()) begin
      w[31:20] = {11'b0, next_bit()};
      w[14:12] = 3'd0;
    end
    return w;
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (exp === act) else begin
      n_errors++;
      $display("Error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_rec(input trace_rec_t e, input trace_rec_t a);
    check_val("record.cycle", e.cycle, a.cycle);
    check_val("record.pc", e.pc, a.pc);
    check_val("record.instr", e.instr, a.instr);
    check_val("record.iclass", 32'(e.iclass), 32'(a.iclass));
    check_val("record.rd", 32'(e.rd), 32'(a.rd));
    check_val("record.rd_valid", 32'(e.rd_valid), 32'(a.rd_valid));
    check_val("record.rd_value", e.rd_value, a.rd_value);
    check_val("record.rs1_value", e.rs1_value, a.rs1_value);
    check_val("record.rs2_value", e.rs2_value, a.rs2_value);
    check_val("record.mem_valid", 32'(e.mem_valid), 32'(a.mem_valid));
    check_val("record.mem_we", 32'(e.mem_we), 32'(a.mem_we));
    check_val("record.mem_addr", e.mem_addr, a.mem_addr);
    check_val("record.mem_wdata", e.mem_wdata, a.mem_wdata);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // model step on the inputs sampled at this edge, then new inputs
  ////////////////////////////////////////////////////////////////////////////

  task automatic model_step();
    trace_rec_t nr;
    trace_rec_t ex_u;
    trace_rec_t wb_u;
    logic       issue;
    logic       ex_ret;
    logic       done;
    logic       rise;
    logic       pop;
    int         space;
    ex_u   = m_ex;
    wb_u   = m_wb;
    ex_ret = 1'b0;
    done   = 1'b0;
    m_started = m_started || fetch_enable;
    issue = m_started && ((id_valid && is_decoding) || pipe_flush);
    nr = '0;
    nr.cycle     = m_cycle;
    nr.pc        = pc;
    nr.instr     = instr;
    nr.iclass    = expected_class(instr);
    nr.rd        = instr[11:7];
    nr.rd_valid  = (instr[11:7] != 5'd0) && (nr.iclass inside {cls_lui, cls_auipc, cls_jal,
                   cls_jalr, cls_op_imm, cls_op, cls_load, cls_csr});
    nr.rs1_value = rs1_value;
    nr.rs2_value = rs2_value;
    if (m_ex_occ) begin
      if (ex_obs.reg_we && ex_u.rd_valid && ex_obs.reg_addr == ex_u.rd)
        ex_u.rd_value = ex_obs.reg_wdata;
      if (ex_obs.data_req && ex_obs.data_gnt && !m_ex.mem_valid) begin
        ex_u.mem_valid = 1'b1;
        ex_u.mem_we    = ex_obs.data_we;
        ex_u.mem_addr  = ex_obs.data_addr;
        ex_u.mem_wdata = ex_obs.data_we ? ex_obs.data_wdata : 32'h0;
      end
      ex_ret = ex_obs.ex_valid || ex_obs.wb_bypass;
    end
    if (m_wb_occ) begin
      if (wb_obs.reg_we && wb_u.rd_valid && wb_obs.reg_addr == wb_u.rd)
        wb_u.rd_value = wb_obs.reg_wdata;
      done = wb_obs.wb_valid;
    end
    // output FIFO, older WB record first
    rise  = !m_req && !trace_ack && (mq.size() > 0);
    pop   = m_req && trace_ack;
    space = depth - mq.size();
    if (done) begin
      if (space > 0) begin
        mq.push_back(wb_u);
        space--;
      end else if (m_drops != 16'hffff) m_drops++;
    end
    if (ex_ret && ex_obs.wb_bypass) begin
      if (space > 0) mq.push_back(ex_u);
      else if (m_drops != 16'hffff) m_drops++;
    end
    if (pop) void'(mq.pop_front());
    if (rise) m_req = 1'b1;
    else if (pop) m_req = 1'b0;
    if (ex_ret && !ex_obs.wb_bypass) begin
      m_wb = ex_u;
      m_wb_occ = 1'b1;
    end else if (done) m_wb_occ = 1'b0;
    else m_wb = wb_u;
    if (issue) begin
      m_ex = nr;
      m_ex_occ = 1'b1;
      n_issued++;
    end else if (ex_ret) m_ex_occ = 1'b0;
    else m_ex = ex_u;
    m_cycle++;
  endtask

  task automatic drive_next();
    ex_obs_t ex_n;
    wb_obs_t wb_n;
    logic    ex_go;
    logic    dec;
    ex_n.ex_valid  = 1'b0;
    ex_n.wb_bypass = 1'b0;
    ex_n.reg_we    = next_bit();
    ex_n.reg_addr  = next_bit() ? m_ex.rd : 5'(rand_bits(5));
    ex_n.reg_wdata = rand_bits(32);
    ex_n.data_req  = next_bit();
    ex_n.data_gnt  = next_bit();
    ex_n.data_we   = next_bit();
    ex_n.data_addr = rand_bits(32);
    ex_n.data_wdata = rand_bits(32);
    wb_n.wb_valid  = m_wb_occ && (rand_bits(2) != 0);
    wb_n.reg_we    = next_bit();
    wb_n.reg_addr  = next_bit() ? m_wb.rd : 5'(rand_bits(5));
    wb_n.reg_wdata = rand_bits(32);
    ex_go = m_ex_occ && (rand_bits(2) == 0);
    // bypass only for jumps and branches, WB hand-over only into a free slot
    if (ex_go && m_ex.iclass inside {cls_branch, cls_jal, cls_jalr} && next_bit())
      ex_n.wb_bypass = 1'b1;
    else if (ex_go && (!m_wb_occ || wb_n.wb_valid))
      ex_n.ex_valid = 1'b1;
    dec = (n_issued < n_instr) && (!m_ex_occ || ex_n.ex_valid || ex_n.wb_bypass);
    ex_obs       <= ex_n;
    wb_obs       <= wb_n;
    // toggles after the first rise, the start latch has to hold
    fetch_enable <= (cyc >= 16) && next_bit();
    id_valid     <= dec && next_bit();
    is_decoding  <= next_bit();
    pipe_flush   <= dec && (rand_bits(4) == 0);
    pc           <= rand_bits(32);
    instr        <= make_instr();
    rs1_value    <= rand_bits(32);
    rs2_value    <= rand_bits(32);
    // ack after a random delay, sometimes a long pause
    if (m_req && !trace_ack) begin
      if (ack_delay == 0) trace_ack <= 1'b1;
      else ack_delay--;
    end else if (!m_req && trace_ack) begin
      trace_ack <= 1'b0;
      ack_delay = (rand_bits(4) == 0) ? 48 + int'(rand_bits(5)) : int'(rand_bits(2));
    end
  endtask

  always @(posedge clk) begin
    if (rst_n && !finished && !timed_out) begin
      model_step();
      cyc++;
      if (n_issued == n_instr && !m_ex_occ && !m_wb_occ && mq.size() == 0 &&
          !m_req && !trace_ack) finished = 1'b1;
      else if (cyc > max_cycle) timed_out = 1'b1;
      else drive_next();
    end
  end

  // outputs are compared half a cycle after the edge
  always @(negedge clk) begin
    if (rst_n && !finished && !timed_out) begin
      check_val("trace_req", 32'(m_req), 32'(trace_req));
      check_val("dropped_count", 32'(m_drops), 32'(dropped_count));
      if (trace_req && m_req && !phase_checked) begin
        assert (mq.size() > 0) else begin
          n_errors++;
          $display("Record delivered while the model FIFO is empty");
        end
        if (mq.size() > 0) check_rec(mq[0], trace_rec);
        phase_checked = 1'b1;
        n_checked++;
      end
      if (!trace_req) phase_checked = 1'b0;
    end
  end

  initial begin
    lfsr_state = 32'h4193_12e3;
    rst_n = 1'b0;
    fetch_enable = 1'b0;
    pc = '0;
    instr = '0;
    id_valid = 1'b0;
    is_decoding = 1'b0;
    pipe_flush = 1'b0;
    rs1_value = '0;
    rs2_value = '0;
    ex_obs = '0;
    wb_obs = '0;
    trace_ack = 1'b0;
    m_ex = '0;
    m_wb = '0;
    m_ex_occ = 1'b0;
    m_wb_occ = 1'b0;
    m_started = 1'b0;
    m_req = 1'b0;
    m_drops = '0;
    m_cycle = '0;
    n_issued = 0;
    n_checked = 0;
    n_errors = 0;
    cyc = 0;
    ack_delay = 0;
    phase_checked = 1'b0;
    finished = 1'b0;
    timed_out = 1'b0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    wait (finished || timed_out);
    if (timed_out) $display("Timeout: the tracer did not drain within %0d cycles", max_cycle);
    $display("Summary: %0d issued, %0d records checked, %0d dropped, %0d errors",
             n_issued, n_checked, m_drops, n_errors);
    if (n_errors == 0 && !timed_out) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// File: list.f
rtl/trace_pkg.sv
rtl/instr_classifier.sv
rtl/trace_issue.sv
rtl/ex_tracker.sv
rtl/wb_tracker.sv
rtl/trace_emitter.sv
rtl/riscv_trace_top.sv
sim/tracer_properties.sv
sim/tb_tracer.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the tracer testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module tb_tracer -o vtb_tracer
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out=$(./obj_dir/vtb_tracer)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "No errors"; then
  exit 0
fi
exit 1
